// File: logic/hw_mgr_cfg.svh
`ifndef HW_MGR_CFG_SVH
`define HW_MGR_CFG_SVH

// Board count and phase timer width
`define HW_MGR_NUM_BOARDS 8
`define HW_MGR_TIMER_W 32

// Sequencer delays in clock cycles
// Simulation values, hardware runs at 100 MHz with ms to s delays

// Settle time before spi_off is trusted
`define HW_MGR_SPI_SETTLE 10
`define HW_MGR_SPI_RESET_WAIT 60
`define HW_MGR_SHUTDOWN_FORCE_DELAY 20
`define HW_MGR_SPI_START_WAIT 60
// Low time of n_shutdown_rst, minus one
`define HW_MGR_SHUTDOWN_RESET_PULSE 5
`define HW_MGR_SHUTDOWN_RESET_DELAY 20

`endif

// File: logic/hw_mgr_state_pkg.sv
`default_nettype none

package hw_mgr_state_pkg;

  // Sequencer states, encoding is visible to software
  typedef enum logic [3:0] {
    IDLE              = 4'd1,
    CONFIRM_SPI_RST   = 4'd2,
    POWER_ON_CTRL_BRD = 4'd3,
    CONFIRM_SPI_START = 4'd4,
    POWER_ON_AMP_BRD  = 4'd5,
    AMP_POWER_WAIT    = 4'd6,
    RUNNING           = 4'd7,
    HALTING           = 4'd8,
    HALTED            = 4'd9
  } seq_state_t;

  // Status word read by the PS
  // Board in the top bits, state in the bottom nibble
  typedef struct packed {
    logic [2:0]  board_num;   // Faulting board, 0 if none
    logic [24:0] status_code; // Cause of the last halt
    seq_state_t  state;       // Current sequencer state
  } status_word_t;

endpackage

`default_nettype wire

// File: logic/hw_mgr_fault_pkg.sv
`default_nettype none

`include "hw_mgr_cfg.svh"

package hw_mgr_fault_pkg;

  // Status codes, upper byte is the group
  typedef enum logic [24:0] {
    EMPTY              = 25'h000,
    OK                 = 25'h001,
    PS_SHUTDOWN        = 25'h002,
    // SPI subsystem
    SPI_RESET_TIMEOUT  = 25'h100,
    SPI_START_TIMEOUT  = 25'h101,
    // Configuration
    LOCK_VIOL          = 25'h200,
    SYS_EN_OOB         = 25'h201,
    CMD_BUF_RESET_OOB  = 25'h202,
    DATA_BUF_RESET_OOB = 25'h203,
    MOSI_SCK_POL_OOB   = 25'h209,
    MISO_SCK_POL_OOB   = 25'h20A,
    // Shutdown sense
    SHUTDOWN_SENSE     = 25'h300,
    EXT_SHUTDOWN       = 25'h301,
    OVER_THRESH        = 25'h400, // Integrator
    BAD_TRIG_CMD       = 25'h500, // Trigger
    // DAC channels
    DAC_BOOT_FAIL      = 25'h600,
    BAD_DAC_CMD        = 25'h601,
    // ADC channels
    ADC_BOOT_FAIL      = 25'h700,
    BAD_ADC_CMD        = 25'h701
  } status_code_t;

  // One flag per amplifier board
  typedef logic [`HW_MGR_NUM_BOARDS-1:0] board_vec_t;
  typedef logic [$clog2(`HW_MGR_NUM_BOARDS)-1:0] board_num_t;

  // Index of the lowest flagged board
  function automatic board_num_t locate_board(board_vec_t vec);
    board_num_t idx;
    idx = '0; // No board flagged
    // Walk down so the lowest set bit wins
    for (int i = `HW_MGR_NUM_BOARDS - 1; i >= 0; i--) begin
      if (vec[i]) begin
        idx = board_num_t'(i);
      end
    end
    return idx;
  endfunction

endpackage

`default_nettype wire

// File: logic/fault_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module fault_arbiter (
  input  wire                           ext_en,             // External enable, low stops
  input  wire                           lock_viol,
  input  wire                           sys_en_oob,
  input  wire                           cmd_buf_reset_oob,
  input  wire                           data_buf_reset_oob,
  input  wire                           mosi_sck_pol_oob,
  input  wire                           miso_sck_pol_oob,
  input  wire                           bad_trig_cmd,
  input  wire hw_mgr_fault_pkg::board_vec_t shutdown_sense,
  input  wire hw_mgr_fault_pkg::board_vec_t over_thresh,
  input  wire hw_mgr_fault_pkg::board_vec_t dac_boot_fail,
  input  wire hw_mgr_fault_pkg::board_vec_t adc_boot_fail,
  input  wire hw_mgr_fault_pkg::board_vec_t bad_dac_cmd,
  input  wire hw_mgr_fault_pkg::board_vec_t bad_adc_cmd,
  output logic                          ext_stop,           // Startup abort
  output logic                          prestart_fault,
  output hw_mgr_fault_pkg::status_code_t prestart_code,
  output logic                          boot_fault,
  output hw_mgr_fault_pkg::status_code_t boot_code,
  output hw_mgr_fault_pkg::board_num_t  boot_board,
  output logic                          run_fault,
  output hw_mgr_fault_pkg::status_code_t run_code,
  output hw_mgr_fault_pkg::board_num_t  run_board
);

  // Per-board vectors reduced to one flag each
  logic any_sense;
  logic any_thresh;
  logic any_dac_boot;
  logic any_adc_boot;
  logic any_dac_cmd;
  logic any_adc_cmd;

  assign any_sense    = |shutdown_sense;
  assign any_thresh   = |over_thresh;
  assign any_dac_boot = |dac_boot_fail;
  assign any_adc_boot = |adc_boot_fail;
  assign any_dac_cmd  = |bad_dac_cmd;
  assign any_adc_cmd  = |bad_adc_cmd;

  assign ext_stop = !ext_en; // Code fixed at EXT_SHUTDOWN

  // Pre-start checks, only looked at in IDLE
  always_comb begin
    prestart_fault = 1'b1;
    prestart_code  = hw_mgr_fault_pkg::EMPTY;
    if (!ext_en) prestart_code = hw_mgr_fault_pkg::EXT_SHUTDOWN;
    else if (sys_en_oob) prestart_code = hw_mgr_fault_pkg::SYS_EN_OOB;
    else if (cmd_buf_reset_oob) prestart_code = hw_mgr_fault_pkg::CMD_BUF_RESET_OOB;
    else if (data_buf_reset_oob) prestart_code = hw_mgr_fault_pkg::DATA_BUF_RESET_OOB;
    else if (mosi_sck_pol_oob) prestart_code = hw_mgr_fault_pkg::MOSI_SCK_POL_OOB;
    else if (miso_sck_pol_oob) prestart_code = hw_mgr_fault_pkg::MISO_SCK_POL_OOB;
    else prestart_fault = 1'b0;
  end

  // Channel boot failures during SPI start, DAC side first
  always_comb begin
    boot_fault = any_dac_boot || any_adc_boot;
    boot_code  = hw_mgr_fault_pkg::EMPTY;
    boot_board = '0;
    if (any_dac_boot) begin
      boot_code  = hw_mgr_fault_pkg::DAC_BOOT_FAIL;
      boot_board = hw_mgr_fault_pkg::locate_board(dac_boot_fail);
    end else if (any_adc_boot) begin
      boot_code  = hw_mgr_fault_pkg::ADC_BOOT_FAIL;
      boot_board = hw_mgr_fault_pkg::locate_board(adc_boot_fail);
    end
  end

  // Runtime chain, sys_en is ranked above this in the sequencer
  always_comb begin
    run_fault = 1'b1;
    run_code  = hw_mgr_fault_pkg::EMPTY;
    run_board = '0;
    if (lock_viol) run_code = hw_mgr_fault_pkg::LOCK_VIOL;
    else if (mosi_sck_pol_oob) run_code = hw_mgr_fault_pkg::MOSI_SCK_POL_OOB;
    else if (miso_sck_pol_oob) run_code = hw_mgr_fault_pkg::MISO_SCK_POL_OOB;
    else if (any_sense) begin
      run_code  = hw_mgr_fault_pkg::SHUTDOWN_SENSE;
      run_board = hw_mgr_fault_pkg::locate_board(shutdown_sense);
    end else if (!ext_en) run_code = hw_mgr_fault_pkg::EXT_SHUTDOWN;
    else if (any_thresh) begin
      run_code  = hw_mgr_fault_pkg::OVER_THRESH;
      run_board = hw_mgr_fault_pkg::locate_board(over_thresh);
    end else if (bad_trig_cmd) run_code = hw_mgr_fault_pkg::BAD_TRIG_CMD;
    else if (any_dac_cmd) begin
      run_code  = hw_mgr_fault_pkg::BAD_DAC_CMD;
      run_board = hw_mgr_fault_pkg::locate_board(bad_dac_cmd);
    end else if (any_adc_cmd) begin
      run_code  = hw_mgr_fault_pkg::BAD_ADC_CMD;
      run_board = hw_mgr_fault_pkg::locate_board(bad_adc_cmd);
    end else run_fault = 1'b0;

    // Every runtime cause must carry a real code
    if (run_fault) begin
      assert (run_code != hw_mgr_fault_pkg::EMPTY && run_code != hw_mgr_fault_pkg::OK)
        else $error("fault_arbiter: run_fault without a cause code");
    end
  end

endmodule

`default_nettype wire

// File: logic/power_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "hw_mgr_cfg.svh"

module power_sequencer #(
  parameter int SPI_SETTLE           = `HW_MGR_SPI_SETTLE,
  parameter int SPI_RESET_WAIT       = `HW_MGR_SPI_RESET_WAIT,
  parameter int SHUTDOWN_FORCE_DELAY = `HW_MGR_SHUTDOWN_FORCE_DELAY,
  parameter int SPI_START_WAIT       = `HW_MGR_SPI_START_WAIT,
  parameter int SHUTDOWN_RESET_PULSE = `HW_MGR_SHUTDOWN_RESET_PULSE,
  parameter int SHUTDOWN_RESET_DELAY = `HW_MGR_SHUTDOWN_RESET_DELAY
) (
  input  wire                            clk,
  input  wire                            aresetn,
  input  wire                            sys_en,         // Software on/off
  input  wire                            spi_off,        // SPI subsystem idle
  input  wire                            calc_n_cs_done, // n_cs timing ready
  input  wire                            ext_stop,
  input  wire                            prestart_fault,
  input  wire hw_mgr_fault_pkg::status_code_t prestart_code,
  input  wire                            boot_fault,
  input  wire hw_mgr_fault_pkg::status_code_t boot_code,
  input  wire hw_mgr_fault_pkg::board_num_t  boot_board,
  input  wire                            run_fault,
  input  wire hw_mgr_fault_pkg::status_code_t run_code,
  input  wire hw_mgr_fault_pkg::board_num_t  run_board,
  output logic                           unlock_cfg,
  output logic                           spi_clk_gate,
  output logic                           spi_en,
  output logic                           shutdown_sense_en,
  output logic                           block_bufs,
  output logic                           n_shutdown_force,
  output logic                           n_shutdown_rst,
  output logic                           ps_interrupt,
  output hw_mgr_state_pkg::status_word_t status_word
);

  hw_mgr_state_pkg::seq_state_t  state;
  logic [`HW_MGR_TIMER_W-1:0]    timer; // Cycles spent in current phase
  hw_mgr_fault_pkg::status_code_t code;
  hw_mgr_fault_pkg::board_num_t  board;

  assign status_word = {board, code, state};

  always_ff @(posedge clk) begin
    if (!aresetn) begin
      state             <= hw_mgr_state_pkg::IDLE;
      timer             <= '0;
      code              <= hw_mgr_fault_pkg::OK;
      board             <= '0;
      unlock_cfg        <= 1'b1;
      spi_clk_gate      <= 1'b0;
      spi_en            <= 1'b0;
      shutdown_sense_en <= 1'b0;
      block_bufs        <= 1'b1;
      n_shutdown_force  <= 1'b0; // Amps held off
      n_shutdown_rst    <= 1'b1;
      ps_interrupt      <= 1'b0;
    end else begin
      case (state)
        hw_mgr_state_pkg::IDLE: begin
          if (sys_en && prestart_fault) begin
            state <= hw_mgr_state_pkg::HALTING;
            code  <= prestart_code;
            board <= '0;
          end else if (sys_en) begin
            state      <= hw_mgr_state_pkg::CONFIRM_SPI_RST;
            timer      <= '0;
            unlock_cfg <= 1'b0; // Freeze config
          end
        end

        // SPI must come out of reset idle
        hw_mgr_state_pkg::CONFIRM_SPI_RST: begin
          if (ext_stop) begin
            state <= hw_mgr_state_pkg::HALTING;
            code  <= hw_mgr_fault_pkg::EXT_SHUTDOWN;
          end else if (timer >= SPI_SETTLE && spi_off && calc_n_cs_done) begin
            state            <= hw_mgr_state_pkg::POWER_ON_CTRL_BRD;
            timer            <= '0;
            n_shutdown_force <= 1'b1;
          end else if (timer >= SPI_RESET_WAIT) begin
            state <= hw_mgr_state_pkg::HALTING;
            code  <= hw_mgr_fault_pkg::SPI_RESET_TIMEOUT;
          end else begin
            timer <= timer + 1'b1;
          end
        end

        // Let the control board supplies come up
        hw_mgr_state_pkg::POWER_ON_CTRL_BRD: begin
          if (ext_stop) begin
            state <= hw_mgr_state_pkg::HALTING;
            code  <= hw_mgr_fault_pkg::EXT_SHUTDOWN;
          end else if (timer >= SHUTDOWN_FORCE_DELAY) begin
            state        <= hw_mgr_state_pkg::CONFIRM_SPI_START;
            timer        <= '0;
            spi_en       <= 1'b1;
            spi_clk_gate <= 1'b1;
          end else begin
            timer <= timer + 1'b1;
          end
        end

        // spi_off falling means the channels booted
        hw_mgr_state_pkg::CONFIRM_SPI_START: begin
          if (ext_stop) begin
            state <= hw_mgr_state_pkg::HALTING;
            code  <= hw_mgr_fault_pkg::EXT_SHUTDOWN;
          end else if (!spi_off) begin
            state          <= hw_mgr_state_pkg::POWER_ON_AMP_BRD;
            timer          <= '0;
            n_shutdown_rst <= 1'b0; // Start of reset pulse
          end else if (boot_fault) begin
            state <= hw_mgr_state_pkg::HALTING;
            code  <= boot_code;
            board <= boot_board;
          end else if (timer >= SPI_START_WAIT) begin
            state <= hw_mgr_state_pkg::HALTING;
            code  <= hw_mgr_fault_pkg::SPI_START_TIMEOUT;
          end else begin
            timer <= timer + 1'b1;
          end
        end

        hw_mgr_state_pkg::POWER_ON_AMP_BRD: begin
          if (ext_stop) begin
            state <= hw_mgr_state_pkg::HALTING;
            code  <= hw_mgr_fault_pkg::EXT_SHUTDOWN;
          end else if (timer >= SHUTDOWN_RESET_PULSE) begin
            state          <= hw_mgr_state_pkg::AMP_POWER_WAIT;
            timer          <= '0;
            n_shutdown_rst <= 1'b1;
          end else begin
            timer <= timer + 1'b1;
          end
        end

        // Power stage settling before buffers open
        hw_mgr_state_pkg::AMP_POWER_WAIT: begin
          if (ext_stop) begin
            state <= hw_mgr_state_pkg::HALTING;
            code  <= hw_mgr_fault_pkg::EXT_SHUTDOWN;
          end else if (timer >= SHUTDOWN_RESET_DELAY) begin
            state             <= hw_mgr_state_pkg::RUNNING;
            timer             <= '0;
            shutdown_sense_en <= 1'b1;
            block_bufs        <= 1'b0;
            ps_interrupt      <= 1'b1; // Tell the PS we are up
          end else begin
            timer <= timer + 1'b1;
          end
        end

        hw_mgr_state_pkg::RUNNING: begin
          if (ps_interrupt) begin
            ps_interrupt <= 1'b0; // Faults watched from next cycle
          end else if (!sys_en || run_fault) begin
            state      <= hw_mgr_state_pkg::HALTING;
            block_bufs <= 1'b1; // Stop traffic at once
            code       <= sys_en ? run_code : hw_mgr_fault_pkg::PS_SHUTDOWN;
            board      <= sys_en ? run_board : '0;
          end
        end

        // Drop every control back to its safe level
        hw_mgr_state_pkg::HALTING: begin
          state             <= hw_mgr_state_pkg::HALTED;
          timer             <= '0;
          unlock_cfg        <= 1'b1;
          spi_clk_gate      <= 1'b0;
          spi_en            <= 1'b0;
          shutdown_sense_en <= 1'b0;
          block_bufs        <= 1'b1;
          n_shutdown_force  <= 1'b0;
          n_shutdown_rst    <= 1'b1;
          ps_interrupt      <= 1'b1;
        end

        hw_mgr_state_pkg::HALTED: begin
          ps_interrupt <= 1'b0;
          if (!sys_en) begin
            state      <= hw_mgr_state_pkg::IDLE;
            code       <= hw_mgr_fault_pkg::OK;
            board      <= '0;
            unlock_cfg <= 1'b1;
          end
        end

        // Illegal encoding, park in HALTED with an empty code
        default: begin
          state             <= hw_mgr_state_pkg::HALTED;
          timer             <= '0;
          code              <= hw_mgr_fault_pkg::EMPTY;
          board             <= '0;
          unlock_cfg        <= 1'b1;
          spi_clk_gate      <= 1'b0;
          spi_en            <= 1'b0;
          shutdown_sense_en <= 1'b0;
          block_bufs        <= 1'b1;
          n_shutdown_force  <= 1'b0;
          n_shutdown_rst    <= 1'b1;
          ps_interrupt      <= 1'b1;
        end
      endcase
    end
  end

  // Interrupt is always a single-cycle pulse
  assert property (@(posedge clk) disable iff (!aresetn) ps_interrupt |=> !ps_interrupt);

  // SPI never runs while the shutdown force is applied
  assert property (@(posedge clk) disable iff (!aresetn) spi_en |-> n_shutdown_force);

  // Buffers open only while running
  assert property (@(posedge clk) disable iff (!aresetn)
    !block_bufs |-> state == hw_mgr_state_pkg::RUNNING);

endmodule

`default_nettype wire

// File: logic/shim_hw_manager.sv
`timescale 1ns/1ps
`default_nettype none

module shim_hw_manager (
  input  wire                            clk,
  input  wire                            aresetn,
  input  wire                            sys_en,
  input  wire                            ext_en,
  input  wire                            spi_off,
  input  wire                            calc_n_cs_done,
  input  wire                            lock_viol,
  input  wire                            sys_en_oob,
  input  wire                            cmd_buf_reset_oob,
  input  wire                            data_buf_reset_oob,
  input  wire                            mosi_sck_pol_oob,
  input  wire                            miso_sck_pol_oob,
  input  wire                            bad_trig_cmd,
  input  wire hw_mgr_fault_pkg::board_vec_t shutdown_sense,
  input  wire hw_mgr_fault_pkg::board_vec_t over_thresh,
  input  wire hw_mgr_fault_pkg::board_vec_t dac_boot_fail,
  input  wire hw_mgr_fault_pkg::board_vec_t adc_boot_fail,
  input  wire hw_mgr_fault_pkg::board_vec_t bad_dac_cmd,
  input  wire hw_mgr_fault_pkg::board_vec_t bad_adc_cmd,
  output logic                           unlock_cfg,
  output logic                           spi_clk_gate,
  output logic                           spi_en,
  output logic                           shutdown_sense_en,
  output logic                           block_bufs,
  output logic                           n_shutdown_force,
  output logic                           n_shutdown_rst,
  output logic                           ps_interrupt,
  output hw_mgr_state_pkg::status_word_t status_word
);

  // Arbiter verdicts, combinational
  logic                           ext_stop;
  logic                           prestart_fault;
  hw_mgr_fault_pkg::status_code_t prestart_code;
  logic                           boot_fault;
  hw_mgr_fault_pkg::status_code_t boot_code;
  hw_mgr_fault_pkg::board_num_t   boot_board;
  logic                           run_fault;
  hw_mgr_fault_pkg::status_code_t run_code;
  hw_mgr_fault_pkg::board_num_t   run_board;

  fault_arbiter fault_arbiter_i (
    .ext_en, .lock_viol, .sys_en_oob, .cmd_buf_reset_oob, .data_buf_reset_oob,
    .mosi_sck_pol_oob, .miso_sck_pol_oob, .bad_trig_cmd,
    .shutdown_sense, .over_thresh, .dac_boot_fail, .adc_boot_fail,
    .bad_dac_cmd, .bad_adc_cmd,
    .ext_stop, .prestart_fault, .prestart_code,
    .boot_fault, .boot_code, .boot_board,
    .run_fault, .run_code, .run_board
  );

  // Delays come from the config header defaults
  power_sequencer power_sequencer_i (
    .clk, .aresetn, .sys_en, .spi_off, .calc_n_cs_done,
    .ext_stop, .prestart_fault, .prestart_code,
    .boot_fault, .boot_code, .boot_board,
    .run_fault, .run_code, .run_board,
    .unlock_cfg, .spi_clk_gate, .spi_en, .shutdown_sense_en, .block_bufs,
    .n_shutdown_force, .n_shutdown_rst, .ps_interrupt, .status_word
  );

endmodule

`default_nettype wire

// File: test/tb_cases.svh
// Columns: name, pre-start flags {ext_en low, sys_en, cmd buf, data buf, mosi, miso},
// SPI behavior, boot fail {adc, dac}, runtime causes {sys_en low, bad adc, bad dac, trig,
// thresh, ext_en low, sense, miso, mosi, lock}, expected code, random board, end state
add_case("clean_run_sys_off", 6'b000000, spi_ok, 2'b00, 10'b10_0000_0000, 25'h002, 1'b0, st_halted);
// Pre-start checks from IDLE
add_case("pre_ext_en_low", 6'b100000, spi_ok, 2'b00, 10'b00_0000_0000, 25'h301, 1'b0, st_halted);
add_case("pre_sys_en_oob", 6'b010000, spi_ok, 2'b00, 10'b00_0000_0000, 25'h201, 1'b0, st_halted);
add_case("pre_cmd_buf_reset", 6'b001000, spi_ok, 2'b00, 10'b00_0000_0000, 25'h202, 1'b0, st_halted);
add_case("pre_data_buf_reset", 6'b000100, spi_ok, 2'b00, 10'b00_0000_0000, 25'h203, 1'b0, st_halted);
add_case("pre_mosi_pol", 6'b000010, spi_ok, 2'b00, 10'b00_0000_0000, 25'h209, 1'b0, st_halted);
add_case("pre_miso_pol", 6'b000001, spi_ok, 2'b00, 10'b00_0000_0000, 25'h20A, 1'b0, st_halted);
add_case("pre_cmd_and_miso", 6'b001001, spi_ok, 2'b00, 10'b00_0000_0000, 25'h202, 1'b0, st_halted);
add_case("pre_all_flags", 6'b111111, spi_ok, 2'b00, 10'b00_0000_0000, 25'h301, 1'b0, st_halted);
// SPI start-up problems
add_case("spi_reset_timeout", 6'b000000, spi_stuck, 2'b00, 10'b00_0000_0000, 25'h100, 1'b0, st_halted);
add_case("spi_start_timeout", 6'b000000, spi_dead, 2'b00, 10'b00_0000_0000, 25'h101, 1'b0, st_halted);
add_case("dac_boot_fail", 6'b000000, spi_dead, 2'b01, 10'b00_0000_0000, 25'h600, 1'b1, st_halted);
add_case("adc_boot_fail", 6'b000000, spi_dead, 2'b10, 10'b00_0000_0000, 25'h700, 1'b1, st_halted);
add_case("dac_and_adc_boot", 6'b000000, spi_dead, 2'b11, 10'b00_0000_0000, 25'h600, 1'b1, st_halted);
// Runtime causes, one at a time
add_case("run_lock_viol", 6'b000000, spi_ok, 2'b00, 10'b00_0000_0001, 25'h200, 1'b0, st_halted);
add_case("run_mosi_pol", 6'b000000, spi_ok, 2'b00, 10'b00_0000_0010, 25'h209, 1'b0, st_halted);
add_case("run_miso_pol", 6'b000000, spi_ok, 2'b00, 10'b00_0000_0100, 25'h20A, 1'b0, st_halted);
add_case("run_shutdown_sense", 6'b000000, spi_ok, 2'b00, 10'b00_0000_1000, 25'h300, 1'b1, st_halted);
add_case("run_ext_en_low", 6'b000000, spi_ok, 2'b00, 10'b00_0001_0000, 25'h301, 1'b0, st_halted);
add_case("run_over_thresh", 6'b000000, spi_ok, 2'b00, 10'b00_0010_0000, 25'h400, 1'b1, st_halted);
add_case("run_bad_trig", 6'b000000, spi_ok, 2'b00, 10'b00_0100_0000, 25'h500, 1'b0, st_halted);
add_case("run_bad_dac_cmd", 6'b000000, spi_ok, 2'b00, 10'b00_1000_0000, 25'h601, 1'b1, st_halted);
add_case("run_bad_adc_cmd", 6'b000000, spi_ok, 2'b00, 10'b01_0000_0000, 25'h701, 1'b1, st_halted);
// Two causes, higher rank wins
add_case("run_lock_and_adc", 6'b000000, spi_ok, 2'b00, 10'b01_0000_0001, 25'h200, 1'b0, st_halted);
add_case("run_thresh_and_dac", 6'b000000, spi_ok, 2'b00, 10'b00_1010_0000, 25'h400, 1'b1, st_halted);
add_case("run_sys_off_and_lock", 6'b000000, spi_ok, 2'b00, 10'b10_0000_0001, 25'h002, 1'b0, st_halted);

// File: test/tb_shim_hw_manager.sv
`timescale 1ns/1ps
`default_nettype none

`include "hw_mgr_cfg.svh"

module tb_shim_hw_manager;

  localparam logic [1:0] spi_ok    = 2'd0; // spi_off follows the sequence
  localparam logic [1:0] spi_stuck = 2'd1; // spi_off never rises
  localparam logic [1:0] spi_dead  = 2'd2; // spi_off never falls
  localparam logic [3:0] st_halted = 4'd9; // HALTED encoding

  typedef struct packed {
    logic [5:0]  pre;        // ext_en low, sys_en, cmd buf, data buf, mosi, miso
    logic [1:0]  spi;
    logic [1:0]  boot;       // adc, dac
    logic [9:0]  run;        // Runtime causes injected in RUNNING
    logic [24:0] code;
    logic        rand_board; // Expect the randomly picked board
    logic [3:0]  state;
  } case_t;

  logic clk, aresetn, sys_en, ext_en, spi_off, calc_n_cs_done;
  logic lock_viol, sys_en_oob, cmd_buf_reset_oob, data_buf_reset_oob;
  logic mosi_sck_pol_oob, miso_sck_pol_oob, bad_trig_cmd;
  hw_mgr_fault_pkg::board_vec_t shutdown_sense, over_thresh, dac_boot_fail, adc_boot_fail;
  hw_mgr_fault_pkg::board_vec_t bad_dac_cmd, bad_adc_cmd;
  logic unlock_cfg, spi_clk_gate, spi_en, shutdown_sense_en, block_bufs;
  logic n_shutdown_force, n_shutdown_rst, ps_interrupt;
  hw_mgr_state_pkg::status_word_t status_word;

  case_t case_q[$];
  string name_q[$];
  int errors = 0;
  int passed = 0;
  int failed = 0;
  int cycles = 0;
  int cycle_limit = 0; // Set once the table is loaded

  shim_hw_manager dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Hang guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Run stopped: %0d cycles passed and the tests did not finish", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic add_case(input string name, input logic [5:0] pre, input logic [1:0] spi,
                          input logic [1:0] boot, input logic [9:0] run,
                          input logic [24:0] code, input logic rand_board,
                          input logic [3:0] state);
    case_t c;
    c = '{pre, spi, boot, run, code, rand_board, state};
    name_q.push_back(name);
    case_q.push_back(c);
  endtask

  task automatic check_value(input string test, input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR %s %s: expected %0h, actual %0h", test, what, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (errors == err_before) begin
      passed++;
      $display("PASS %s", name);
    end else begin
      failed++;
      $display("FAIL %s", name);
    end
  endtask

  // Controls {unlock, n_rst, block, n_force, clk_gate, spi_en, sense_en, irq}
  function automatic logic [31:0] control_bits();
    return {24'd0, unlock_cfg, n_shutdown_rst, block_bufs, n_shutdown_force,
            spi_clk_gate, spi_en, shutdown_sense_en, ps_interrupt};
  endfunction

  // Runtime causes with per-board ones on the picked board
  task automatic inject_run(input logic [9:0] run, input hw_mgr_fault_pkg::board_vec_t one_hot);
    lock_viol        = run[0];
    mosi_sck_pol_oob = run[1];
    miso_sck_pol_oob = run[2];
    shutdown_sense   = run[3] ? one_hot : '0;
    ext_en           = !run[4];
    over_thresh      = run[5] ? one_hot : '0;
    bad_trig_cmd     = run[6];
    bad_dac_cmd      = run[7] ? one_hot : '0;
    bad_adc_cmd      = run[8] ? one_hot : '0;
    sys_en           = !run[9];
  endtask

  task automatic clear_inputs();
    inject_run('0, '0);
    sys_en_oob         = 1'b0;
    cmd_buf_reset_oob  = 1'b0;
    data_buf_reset_oob = 1'b0;
    dac_boot_fail      = '0;
    adc_boot_fail      = '0;
    spi_off            = 1'b1; // SPI idle after reset
    calc_n_cs_done     = 1'b1;
    sys_en             = 1'b0;
  endtask

  task automatic run_case(input int idx);
    case_t c;
    int rnd;
    int err_before;
    int rst_low;
    int irq;
    int ran;
    int opened;
    int powered;
    hw_mgr_fault_pkg::board_vec_t one_hot;
    c = case_q[idx];
    err_before = errors;
    rnd = $urandom % `HW_MGR_NUM_BOARDS;
    one_hot = hw_mgr_fault_pkg::board_vec_t'(1) << rnd; // Lowest set bit is rnd itself
    rst_low = 0;
    irq = 0;
    ran = 0;
    opened = 0;
    powered = 0;
    {ext_en, sys_en_oob, cmd_buf_reset_oob, data_buf_reset_oob, mosi_sck_pol_oob,
      miso_sck_pol_oob} = c.pre ^ 6'b100000; // ext_en is active high
    spi_off = (c.spi != spi_stuck);
    sys_en = 1'b1;
    @(negedge clk);
    // Model SPI and inject faults until the machine halts
    while (status_word.state != hw_mgr_state_pkg::HALTED) begin
      if (status_word.state == hw_mgr_state_pkg::CONFIRM_SPI_START) begin
        dac_boot_fail = c.boot[0] ? one_hot : '0;
        adc_boot_fail = c.boot[1] ? one_hot : '0;
        if (c.spi == spi_ok) spi_off = 1'b0; // Channels came up
      end
      if (status_word.state == hw_mgr_state_pkg::RUNNING) begin
        ran = 1;
        if (!block_bufs) opened = 1;
        // Supplies released, SPI clocked and sense armed
        if (n_shutdown_force && spi_en && spi_clk_gate && shutdown_sense_en && !unlock_cfg) begin
          powered = 1;
        end
        if (!ps_interrupt) inject_run(c.run, one_hot); // Sampled after the start pulse
      end
      if (!n_shutdown_rst) rst_low++;
      if (ps_interrupt) irq++;
      @(negedge clk);
    end
    check_value(name_q[idx], "status word", {c.rand_board ? 3'(rnd) : 3'd0, c.code, c.state},
                status_word);
    check_value(name_q[idx], "halt interrupt", 32'd1, 32'(ps_interrupt));
    check_value(name_q[idx], "halted controls", 32'h0000_00E1, control_bits()); // Reset levels
    check_value(name_q[idx], "start interrupts", 32'(ran), 32'(irq));
    check_value(name_q[idx], "buffers opened", 32'(ran), 32'(opened));
    check_value(name_q[idx], "power and SPI on", 32'(ran), 32'(powered));
    if (ran != 0) begin
      check_value(name_q[idx], "n_shutdown_rst low cycles", `HW_MGR_SHUTDOWN_RESET_PULSE + 1,
                  32'(rst_low));
    end
    // Back to IDLE with a clean word
    clear_inputs();
    @(negedge clk);
    check_value(name_q[idx], "idle word", 32'h0000_0011, status_word);
    check_value(name_q[idx], "unlock_cfg", 32'd1, 32'(unlock_cfg));
    finish_test(name_q[idx], err_before);
  endtask

  initial begin
    int err_before;
    void'($urandom(21));
    `include "tb_cases.svh"
    cycle_limit = case_q.size() * (`HW_MGR_SPI_SETTLE + `HW_MGR_SPI_RESET_WAIT
      + `HW_MGR_SHUTDOWN_FORCE_DELAY + `HW_MGR_SPI_START_WAIT
      + `HW_MGR_SHUTDOWN_RESET_PULSE + `HW_MGR_SHUTDOWN_RESET_DELAY + 50);
    aresetn = 1'b0;
    clear_inputs();
    repeat (3) @(posedge clk);
    @(negedge clk);
    aresetn = 1'b1;
    @(negedge clk);
    err_before = errors;
    check_value("reset", "controls", 32'h0000_00E0, control_bits());
    check_value("reset", "status word", 32'h0000_0011, status_word); // IDLE with OK and board 0
    finish_test("reset", err_before);
    for (int i = 0; i < case_q.size(); i++) begin
      run_case(i);
    end
    $display("Tests: %0d, passed: %0d, failed: %0d, failed checks: %0d",
             passed + failed, passed, failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+logic
+incdir+test
logic/hw_mgr_state_pkg.sv
logic/hw_mgr_fault_pkg.sv
logic/fault_arbiter.sv
logic/power_sequencer.sv
logic/shim_hw_manager.sv
test/tb_shim_hw_manager.sv

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator, the simulation log decides the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tb_shim_hw_manager \
  -o tb_sim > build.log 2>&1 && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
